/* common/tx_pkg.sv */
package tx_pkg;

    // Default sizes, overridable from the top level
    // Bytes per packet
    localparam int PACKET_WIDTH    = 4;
    // Position tag width on every byte
    localparam int INDEX_WIDTH     = 2;
    // Preamble bits ahead of the payload
    localparam int PREAMBLE_LENGTH = 8;
    // Output level width, one bit per DAC pin
    localparam int DATA_WIDTH      = 8;
    // UART oversampling ratio
    localparam int CLKS_PER_BIT    = 16;
    // Clock cycles each output symbol is held
    localparam int SYMBOL_CYCLES   = 4;

    // Alternating pattern, leading one
    localparam logic [7:0] PREAMBLE = 8'b1010_1010;

    // Output levels
    // Full scale for a one
    localparam logic [DATA_WIDTH-1:0] LEVEL_HIGH = {DATA_WIDTH{1'b1}};
    // Zero for a zero
    localparam logic [DATA_WIDTH-1:0] LEVEL_LOW  = {DATA_WIDTH{1'b0}};
    // Midscale while nothing is sent
    localparam logic [DATA_WIDTH-1:0] LEVEL_IDLE = {1'b1, {(DATA_WIDTH - 1){1'b0}}};

    // One tagged byte of the frame, index in the upper bits
    typedef struct packed {
        logic [INDEX_WIDTH-1:0] index;
        logic [7:0]             data;
    } frame_field_t;

    // UART receiver states
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    // Modulator states
    typedef enum logic [1:0] {
        MOD_IDLE,
        MOD_LOAD,
        MOD_SYMBOL
    } mod_state_t;

endpackage

/* rtl/uart_rx.sv */
`timescale 1ns/10ps
module uart_rx #(
    parameter int CLKS_PER_BIT = tx_pkg::CLKS_PER_BIT
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_in,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);
    import tx_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    // Sample point for the start bit re-check
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    // Distance between bit centers
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    logic [1:0]       sync_q;
    logic             rx_line;
    rx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic             stop_wait;
    logic [7:0]       shift_q;

    // Two-flop synchronizer, idles high like the line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], uart_in};
        end
    end

    assign rx_line = sync_q[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= 3'd0;
            stop_wait <= 1'b0;
            rx_valid  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    // Falling edge, candidate start bit
                    if (!rx_line) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= 3'd0;
                        // Still low at mid bit, otherwise a glitch
                        state   <= rx_line ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (stop_wait) begin
                        // Bad stop bit, hold off until the line is back high
                        if (rx_line) begin
                            stop_wait <= 1'b0;
                            state     <= RX_IDLE;
                        end
                    end else if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        if (rx_line) begin
                            rx_valid <= 1'b1;
                            state    <= RX_IDLE;
                        end else begin
                            stop_wait <= 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && clk_cnt == FULL_BIT) begin
            shift_q <= {rx_line, shift_q[7:1]};
        end
    end

    // Stable from the stop bit until the next data bit
    assign rx_byte = shift_q;

endmodule

/* packet/packet_buffer.sv */
`timescale 1ns/10ps
module packet_buffer #(
    parameter int PACKET_WIDTH = tx_pkg::PACKET_WIDTH
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [7:0]                rx_byte,
    input  logic                      rx_valid,
    input  logic                      tx_done,
    output logic [PACKET_WIDTH*8-1:0] packet,
    output logic                      send,
    output logic                      overrun
);

    localparam int CNT_W = $clog2(PACKET_WIDTH + 1);

    logic [CNT_W-1:0] byte_cnt;
    logic             full;
    logic             accept;

    // Full from the last byte until the frame has gone out
    assign full   = (byte_cnt == CNT_W'(PACKET_WIDTH));
    assign accept = rx_valid && !full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= '0;
            send     <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            send <= 1'b0;
            if (tx_done) begin
                byte_cnt <= '0;
            end else if (accept) begin
                byte_cnt <= byte_cnt + 1'b1;
                // Last slot filled, hand the packet on
                if (byte_cnt == CNT_W'(PACKET_WIDTH - 1)) begin
                    send <= 1'b1;
                end
            end
            // Sticky, cleared by reset only
            if (rx_valid && full) begin
                overrun <= 1'b1;
            end
        end
    end

    // First byte lands in the top slot
    always_ff @(posedge clk) begin
        if (accept) begin
            packet[(PACKET_WIDTH - 1 - int'(byte_cnt)) * 8 +: 8] <= rx_byte;
        end
    end

endmodule

/* packet/packet_framer.sv */
`timescale 1ns/10ps
module packet_framer #(
    parameter  int PACKET_WIDTH    = tx_pkg::PACKET_WIDTH,
    parameter  int INDEX_WIDTH     = tx_pkg::INDEX_WIDTH,
    parameter  int PREAMBLE_LENGTH = tx_pkg::PREAMBLE_LENGTH,
    localparam int FIELD_BITS      = 8 + INDEX_WIDTH,
    localparam int FRAME_BITS      = PREAMBLE_LENGTH + PACKET_WIDTH * FIELD_BITS
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [PACKET_WIDTH*8-1:0] packet,
    input  logic                      send,
    input  logic                      tx_done,
    output logic [FRAME_BITS-1:0]     frame,
    output logic                      frame_ready
);
    import tx_pkg::*;

    frame_field_t          field_c;
    logic [FRAME_BITS-1:0] frame_next;

    // Frame layout, MSB first on the wire
    // Preamble on top, then field 0 down to field PACKET_WIDTH-1
    always_comb begin
        frame_next = '0;
        field_c    = '0;
        frame_next[FRAME_BITS-1 -: PREAMBLE_LENGTH] = PREAMBLE;
        for (int i = 0; i < PACKET_WIDTH; i++) begin
            // Tag each byte with its arrival position
            field_c.index = INDEX_WIDTH'(i);
            // Byte i sits in slot i counted from the top
            field_c.data  = packet[(PACKET_WIDTH - 1 - i) * 8 +: 8];
            frame_next[(PACKET_WIDTH - 1 - i) * FIELD_BITS +: FIELD_BITS] = field_c;
        end
    end

    // Ready level for the modulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_ready <= 1'b0;
        end else if (tx_done) begin
            frame_ready <= 1'b0;
        end else if (send) begin
            frame_ready <= 1'b1;
        end
    end

    // Frame held steady while it is being sent
    always_ff @(posedge clk) begin
        if (send && !frame_ready) begin
            frame <= frame_next;
        end
    end

endmodule

/* modulator/frame_serializer.sv */
`timescale 1ns/10ps
module frame_serializer #(
    parameter int FRAME_BITS = tx_pkg::PREAMBLE_LENGTH
                             + tx_pkg::PACKET_WIDTH * (8 + tx_pkg::INDEX_WIDTH)
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [FRAME_BITS-1:0] frame,
    input  logic                  load,
    input  logic                  shift,
    output logic                  serial_bit
);

    logic [FRAME_BITS-1:0] shift_q;

    // Parallel load wins over shift
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_q <= '0;
        end else if (load) begin
            shift_q <= frame;
        end else if (shift) begin
            // Zeros fill in behind the last bit
            shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
        end
    end

    // MSB first
    assign serial_bit = shift_q[FRAME_BITS-1];

endmodule

/* modulator/symbol_modulator.sv */
`timescale 1ns/10ps
module symbol_modulator #(
    parameter int FRAME_BITS    = tx_pkg::PREAMBLE_LENGTH
                                + tx_pkg::PACKET_WIDTH * (8 + tx_pkg::INDEX_WIDTH),
    parameter int SYMBOL_CYCLES = tx_pkg::SYMBOL_CYCLES,
    parameter int DATA_WIDTH    = tx_pkg::DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  frame_ready,
    input  logic                  serial_bit,
    output logic                  load,
    output logic                  shift,
    output logic [DATA_WIDTH-1:0] wave,
    output logic                  tx_done,
    output logic                  tx_active
);
    import tx_pkg::*;

    localparam int CYC_W = $clog2(SYMBOL_CYCLES + 1);
    localparam int BIT_W = $clog2(FRAME_BITS + 1);
    localparam logic [CYC_W-1:0] LAST_CYC = CYC_W'(SYMBOL_CYCLES - 1);
    localparam logic [BIT_W-1:0] END_BIT  = BIT_W'(FRAME_BITS);

    mod_state_t       state;
    logic [CYC_W-1:0] cyc_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic             fetch;
    logic             frame_end;

    // All bits taken, last symbol in its final cycle
    assign frame_end = (bit_cnt == END_BIT);
    // Symbol start, take the current bit and advance the serializer
    assign fetch     = (state == MOD_SYMBOL) && (cyc_cnt == '0) && !frame_end;
    assign shift     = fetch;
    assign load      = (state == MOD_LOAD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= MOD_IDLE;
            cyc_cnt   <= '0;
            bit_cnt   <= '0;
            wave      <= LEVEL_IDLE;
            tx_done   <= 1'b0;
            tx_active <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (state)
                MOD_IDLE: begin
                    // frame_ready still high while tx_done is out
                    if (frame_ready && !tx_done) begin
                        state <= MOD_LOAD;
                    end
                end
                MOD_LOAD: begin
                    cyc_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= MOD_SYMBOL;
                end
                MOD_SYMBOL: begin
                    if (frame_end) begin
                        wave      <= LEVEL_IDLE;
                        tx_active <= 1'b0;
                        tx_done   <= 1'b1;
                        state     <= MOD_IDLE;
                    end else begin
                        if (fetch) begin
                            wave      <= serial_bit ? LEVEL_HIGH : LEVEL_LOW;
                            tx_active <= 1'b1;
                        end
                        // Symbol boundary
                        if (cyc_cnt == LAST_CYC) begin
                            cyc_cnt <= '0;
                            bit_cnt <= bit_cnt + 1'b1;
                        end else begin
                            cyc_cnt <= cyc_cnt + 1'b1;
                        end
                    end
                end
                default: state <= MOD_IDLE;
            endcase
        end
    end

endmodule

/* rtl/packet_transmitter.sv */
`timescale 1ns/10ps
module packet_transmitter #(
    parameter int PACKET_WIDTH    = tx_pkg::PACKET_WIDTH,
    parameter int INDEX_WIDTH     = tx_pkg::INDEX_WIDTH,
    parameter int PREAMBLE_LENGTH = tx_pkg::PREAMBLE_LENGTH,
    parameter int DATA_WIDTH      = tx_pkg::DATA_WIDTH,
    parameter int CLKS_PER_BIT    = tx_pkg::CLKS_PER_BIT,
    parameter int SYMBOL_CYCLES   = tx_pkg::SYMBOL_CYCLES
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  uart_in,
    output logic [DATA_WIDTH-1:0] wave,
    output logic                  tx_active,
    output logic                  overrun
);

    // Preamble plus one tagged field per byte
    localparam int FRAME_BITS = PREAMBLE_LENGTH + PACKET_WIDTH * (8 + INDEX_WIDTH);

    // UART to buffer
    logic [7:0]                rx_byte;
    logic                      rx_valid;
    // Buffer to framer
    logic [PACKET_WIDTH*8-1:0] packet;
    logic                      send;
    // Framer to serializer and modulator
    logic [FRAME_BITS-1:0]     frame;
    logic                      frame_ready;
    // Modulator and serializer loop
    logic                      load;
    logic                      shift;
    logic                      serial_bit;
    // End of frame, back to framer and buffer
    logic                      tx_done;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .uart_in (uart_in),
        .rx_byte (rx_byte),
        .rx_valid(rx_valid)
    );

    packet_buffer #(
        .PACKET_WIDTH(PACKET_WIDTH)
    ) u_packet_buffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx_byte (rx_byte),
        .rx_valid(rx_valid),
        .tx_done (tx_done),
        .packet  (packet),
        .send    (send),
        .overrun (overrun)
    );

    packet_framer #(
        .PACKET_WIDTH   (PACKET_WIDTH),
        .INDEX_WIDTH    (INDEX_WIDTH),
        .PREAMBLE_LENGTH(PREAMBLE_LENGTH)
    ) u_packet_framer (
        .clk        (clk),
        .rst_n      (rst_n),
        .packet     (packet),
        .send       (send),
        .tx_done    (tx_done),
        .frame      (frame),
        .frame_ready(frame_ready)
    );

    frame_serializer #(
        .FRAME_BITS(FRAME_BITS)
    ) u_frame_serializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .frame     (frame),
        .load      (load),
        .shift     (shift),
        .serial_bit(serial_bit)
    );

    symbol_modulator #(
        .FRAME_BITS   (FRAME_BITS),
        .SYMBOL_CYCLES(SYMBOL_CYCLES),
        .DATA_WIDTH   (DATA_WIDTH)
    ) u_symbol_modulator (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_ready(frame_ready),
        .serial_bit (serial_bit),
        .load       (load),
        .shift      (shift),
        .wave       (wave),
        .tx_done    (tx_done),
        .tx_active  (tx_active)
    );

endmodule

/* test/tb_tx_tasks.svh */
`ifndef TB_TX_TASKS_SVH
`define TB_TX_TASKS_SVH

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h8020_0003;
    end else begin
        return state >> 1;
    end
endfunction

// One LFSR step per payload bit
task automatic next_random_byte(output logic [7:0] value);
    value = 8'h00;
    for (int n = 0; n < 8; n++) begin
        value      = {value[6:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
    end
endtask

// Holds the line for one UART bit time
// Entered and left DRIVE_DELAY after a rising edge
task automatic line_bit(input logic level);
    uart_in = level;
    repeat (CLKS_PER_BIT) begin
        @(posedge clk);
        #DRIVE_DELAY;
    end
endtask

// Start bit, data LSB first, stop bit
task automatic send_uart_byte(input logic [7:0] value, input logic bad_stop);
    // Realign to the drive point
    @(posedge clk);
    #DRIVE_DELAY;
    line_bit(1'b0);
    for (int n = 0; n < 8; n++) begin
        line_bit(value[n]);
    end
    // Low stop bit for a framing error
    line_bit(!bad_stop);
endtask

task automatic send_packet();
    for (int n = 0; n < PACKET_WIDTH; n++) begin
        send_uart_byte(sent_bytes[n], 1'b0);
    end
endtask

// Rebuilds the frame from the output levels, first symbol to the MSB
task automatic decode_frame();
    wait_active();
    if (timed_out) return;
    // Half a cycle in already, step toward mid symbol
    repeat (SYMBOL_CYCLES / 2 - 1) @(negedge clk);
    for (int bit_pos = FRAME_BITS - 1; bit_pos >= 0; bit_pos--) begin
        decoded_frame[bit_pos] = (wave == LEVEL_HIGH);
        if (bit_pos > 0) repeat (SYMBOL_CYCLES) @(negedge clk);
    end
endtask

// Preamble, then (index, byte) fields in arrival order
function automatic logic [FRAME_BITS-1:0] expected_frame();
    frame_field_t          field;
    logic [FRAME_BITS-1:0] built;
    built = FRAME_BITS'(PREAMBLE);
    for (int n = 0; n < PACKET_WIDTH; n++) begin
        field.index = INDEX_WIDTH'(n);
        field.data  = sent_bytes[n];
        built       = {built[FRAME_BITS-FIELD_BITS-1:0], field};
    end
    return built;
endfunction

`endif

/* test/tb_packet_transmitter.sv */
`timescale 1ns/10ps
module tb_packet_transmitter;
    import tx_pkg::*;

    localparam int FIELD_BITS   = 8 + INDEX_WIDTH;
    localparam int FRAME_BITS   = PREAMBLE_LENGTH + PACKET_WIDTH * FIELD_BITS;
    localparam int FRAME_CYCLES = FRAME_BITS * SYMBOL_CYCLES;
    // Inputs change this long after the rising edge
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 8;
    // Upper bound for any single wait, in clock cycles
    localparam int WAIT_LIMIT   = 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  uart_in;
    logic [DATA_WIDTH-1:0] wave;
    logic                  tx_active;
    logic                  overrun;

    int                    error_count;
    int                    errors_at_start;
    int                    test_count;
    int                    failed_tests;
    int                    active_cycles;
    logic                  timed_out;
    logic [31:0]           lfsr_state;
    // Payload of the packet under test, element 0 sent first
    logic [7:0]            sent_bytes [PACKET_WIDTH];
    logic [FRAME_BITS-1:0] decoded_frame;

    packet_transmitter #(
        .PACKET_WIDTH   (PACKET_WIDTH),
        .INDEX_WIDTH    (INDEX_WIDTH),
        .PREAMBLE_LENGTH(PREAMBLE_LENGTH),
        .DATA_WIDTH     (DATA_WIDTH),
        .CLKS_PER_BIT   (CLKS_PER_BIT),
        .SYMBOL_CYCLES  (SYMBOL_CYCLES)
    ) u_packet_transmitter (
        .clk      (clk),
        .rst_n    (rst_n),
        .uart_in  (uart_in),
        .wave     (wave),
        .tx_active(tx_active),
        .overrun  (overrun)
    );

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Cycles since tx_active rose, zero while idle
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_cycles <= 0;
        end else if (tx_active) begin
            active_cycles <= active_cycles + 1;
        end else begin
            active_cycles <= 0;
        end
    end

    // Midscale whenever no frame is on the wire
    idle_level: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_active |-> wave == LEVEL_IDLE)
        else value_error("wave", 64'($sampled(wave)), 64'(LEVEL_IDLE));

    // Only the two data levels inside a frame
    symbol_level: assert property (@(posedge clk) disable iff (!rst_n)
        tx_active |-> (wave == LEVEL_HIGH || wave == LEVEL_LOW))
        else begin
            error_count++;
            $display("[FAIL] wave=%h is neither LEVEL_HIGH=%h nor LEVEL_LOW=%h",
                     $sampled(wave), LEVEL_HIGH, LEVEL_LOW);
        end

    // Level moves only on symbol boundaries
    symbol_steady: assert property (@(posedge clk) disable iff (!rst_n)
        tx_active && (active_cycles % SYMBOL_CYCLES != 0) |-> $stable(wave))
        else begin
            error_count++;
            $display("wave changed in the middle of a symbol");
        end

    // One frame is FRAME_BITS symbols long
    frame_length: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(tx_active) |-> active_cycles == FRAME_CYCLES)
        else value_error("tx_active cycles", 64'($sampled(active_cycles)), 64'(FRAME_CYCLES));

    task automatic value_error(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        error_count++;
        $display("[FAIL] %s got=%h expected=%h", name, got, want);
    endtask

    task automatic wait_active();
        int count;
        count = 0;
        @(negedge clk);
        while (!tx_active && count < WAIT_LIMIT) begin
            @(negedge clk);
            count++;
        end
        if (!tx_active) begin
            timed_out = 1'b1;
            $display("Timed out waiting for tx_active to rise");
        end
    endtask

    task automatic wait_idle();
        int count;
        count = 0;
        while (tx_active && count < WAIT_LIMIT) begin
            @(negedge clk);
            count++;
        end
        if (tx_active) begin
            timed_out = 1'b1;
            $display("Timed out waiting for tx_active to fall");
        end
        // Let the frame length check fire
        repeat (2) @(negedge clk);
    endtask

    `include "tb_tx_tasks.svh"

    task automatic fill_random();
        for (int n = 0; n < PACKET_WIDTH; n++) begin
            next_random_byte(sent_bytes[n]);
        end
    endtask

    task automatic check_frame();
        logic [FRAME_BITS-1:0] want;
        want = expected_frame();
        if (timed_out) return;
        assert (decoded_frame == want)
            else value_error("frame", 64'(decoded_frame), 64'(want));
    endtask

    // Sends sent_bytes and decodes the frame that comes out
    task automatic transmit_and_check(input logic bad_lead, input logic extra_byte);
        logic [7:0] spare;
        fork
            begin
                if (bad_lead) begin
                    // Framing error, receiver drops it
                    send_uart_byte(8'hE7, 1'b1);
                    line_bit(1'b1);
                    line_bit(1'b1);
                end
                send_packet();
                if (extra_byte) begin
                    // Lands while the buffer is still full
                    wait_active();
                    next_random_byte(spare);
                    if (!timed_out) send_uart_byte(spare, 1'b0);
                end
            end
            decode_frame();
        join
        check_frame();
        if (timed_out) return;
        wait_idle();
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count != errors_at_start || timed_out) begin
            failed_tests++;
            $display("test %0d (%s) FAILED", test_count, name);
        end else begin
            $display("test %0d (%s) passed", test_count, name);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        uart_in      = 1'b1;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        lfsr_state   = 32'h4349;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // Outputs straight out of reset
        start_test();
        repeat (4) @(negedge clk);
        assert (wave == LEVEL_IDLE) else value_error("wave", 64'(wave), 64'(LEVEL_IDLE));
        assert (!tx_active) else value_error("tx_active", 64'(tx_active), 64'h0);
        assert (!overrun) else value_error("overrun", 64'(overrun), 64'h0);
        finish_test("reset state");

        if (!timed_out) begin
            start_test();
            fill_random();
            transmit_and_check(1'b0, 1'b0);
            finish_test("frame content");
        end

        if (!timed_out) begin
            // Long runs of equal bits and single transitions
            start_test();
            for (int n = 0; n < PACKET_WIDTH; n++) begin
                sent_bytes[n] = n[0] ? 8'h0F : 8'hF0;
            end
            transmit_and_check(1'b0, 1'b0);
            finish_test("symbol timing");
        end

        if (!timed_out) begin
            start_test();
            fill_random();
            transmit_and_check(1'b0, 1'b1);
            assert (overrun) else value_error("overrun", 64'(overrun), 64'h1);
            // Next packet must hold fresh bytes only
            fill_random();
            if (!timed_out) transmit_and_check(1'b0, 1'b0);
            finish_test("overrun");
        end

        if (!timed_out) begin
            start_test();
            fill_random();
            transmit_and_check(1'b1, 1'b0);
            finish_test("framing error");
        end

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+test
common/tx_pkg.sv
rtl/uart_rx.sv
packet/packet_buffer.sv
packet/packet_framer.sv
modulator/frame_serializer.sv
modulator/symbol_modulator.sv
rtl/packet_transmitter.sv
test/tb_packet_transmitter.sv

/* Makefile */
# Verilator build and run for the packet transmitter testbench

SIM = obj_dir/sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_packet_transmitter -Mdir obj_dir -o sim -f all.f

run: compile
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Something failed" sim.log; then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@grep -q "Everything OK" sim.log || { echo "No pass line in sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log
